// ==== hdl/isa_pkg.sv ====
package isa_pkg;

   // Major opcodes handled by the core, anything else decodes to OTHER
   typedef enum logic [6:0] {
      OP_IMM = 7'b0010011,
      OP     = 7'b0110011,
      LUI    = 7'b0110111,
      BRANCH = 7'b1100011,
      JAL    = 7'b1101111,
      OTHER  = 7'b0000000
   } opcode_e;

   // ALU funct3 codes; BEQ and BNE share the codes of ADD and SLL
   typedef enum logic [2:0] {
      F3_ADD_EQ = 3'b000,
      F3_SLL_NE = 3'b001,
      F3_SLT    = 3'b010,
      F3_SLTU   = 3'b011,
      F3_XOR    = 3'b100,
      F3_SR     = 3'b101,
      F3_OR     = 3'b110,
      F3_AND    = 3'b111
   } funct3_e;

   typedef logic [31:0] instr_t;

   // x0 reads as zero and is never written
   typedef logic [4:0] reg_idx_t;

endpackage

// ==== hdl/core_pkg.sv ====
package core_pkg;

   // BRANCH2 is the second pass of any two-stage op (branches and SLT/SLTU)
   typedef enum logic [2:0] {
      IDLE,
      FETCH,
      READ,
      EXEC,
      BRANCH2
   } state_e;

   // Bit position of the current slice
   typedef logic [4:0] bitcnt_t;

   typedef logic [31:0] data_t;

   typedef logic [31:0] pc_t;

endpackage

// ==== hdl/serial_state.sv ====
`timescale 1ns/1ps

module serial_state import core_pkg::*; #(
   parameter int W = 4
) (
   input  logic clk,
   input  logic i_rst_n,
   input  logic i_ibus_ack,
   input  logic i_rf_ready,
   input  logic i_two_stage_op,
   input  logic i_branch_op,
   input  logic i_branch_ne,
   input  logic i_cmp_result,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_en,
   output logic o_cnt0,
   output logic o_cnt_last,
   output logic o_init,
   output logic o_pc_en,
   output logic o_take_branch
);

   state_e  state;
   bitcnt_t cnt;

   assign o_ibus_cyc = (state == FETCH);
   // IDLE is the decode cycle right after the ack and issues the read
   assign o_rf_rreq  = (state == IDLE);
   assign o_cnt_en   = (state == EXEC) || (state == BRANCH2);
   assign o_cnt0     = o_cnt_en && (cnt == '0);
   assign o_cnt_last = o_cnt_en && (cnt == bitcnt_t'(32 - W));

   // First pass of a two-stage op only compares
   assign o_init  = (state == EXEC) && i_two_stage_op;
   assign o_pc_en = o_cnt_en && !o_init;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state         <= FETCH;
         cnt           <= '0;
         o_take_branch <= 1'b0;
      end else begin
         if (o_cnt_en) begin
            cnt <= cnt + bitcnt_t'(W);
         end
         case (state)
            FETCH: begin
               o_take_branch <= 1'b0;
               if (i_ibus_ack) begin
                  state <= IDLE;
               end
            end
            IDLE: begin
               state <= i_rf_ready ? EXEC : READ;
            end
            READ: begin
               if (i_rf_ready) begin
                  state <= EXEC;
               end
            end
            EXEC: begin
               if (o_cnt_last) begin
                  if (o_init && i_branch_op) begin
                     o_take_branch <= i_cmp_result ^ i_branch_ne;
                  end
                  state <= i_two_stage_op ? BRANCH2 : FETCH;
               end
            end
            BRANCH2: begin
               if (o_cnt_last) begin
                  state <= FETCH;
               end
            end
            default: begin
               state <= FETCH;
            end
         endcase
      end
   end

   // The counter wraps to zero at the end of every pass
   a_cnt_zero_between_passes: assert property (@(posedge clk) disable iff (!i_rst_n)
      !o_cnt_en |-> (cnt == '0));

   // A branch decision steers only the second pass and ends at the next fetch
   a_take_branch_scope: assert property (@(posedge clk) disable iff (!i_rst_n)
      o_take_branch |-> ((state == BRANCH2) || (state == FETCH)));

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode import isa_pkg::*; (
   input  logic       clk,
   input  logic       i_ibus_ack,
   input  instr_t     i_ibus_rdt,
   output logic       o_alu_sub,
   output logic [1:0] o_alu_bool_op,
   output logic       o_alu_cmp_eq,
   output logic       o_alu_cmp_sig,
   output logic [1:0] o_alu_rd_sel,
   output logic       o_op_b_imm,
   output logic [1:0] o_rd_sel,
   output logic       o_writes_rd,
   output logic       o_two_stage_op,
   output logic       o_branch_op,
   output logic       o_branch_ne,
   output logic       o_jal_op,
   output logic [1:0] o_imm_fmt
);

   instr_t  word;
   opcode_e opcode;
   funct3_e funct3;
   logic    arith;
   logic    arith_ok;
   logic    slt_op;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         word <= i_ibus_rdt;
      end
   end

   always_comb begin
      case (word[6:0])
         OP_IMM:  opcode = OP_IMM;
         OP:      opcode = OP;
         LUI:     opcode = LUI;
         BRANCH:  opcode = BRANCH;
         JAL:     opcode = JAL;
         default: opcode = OTHER;
      endcase
   end

   assign funct3 = funct3_e'(word[14:12]);
   assign arith  = (opcode == OP_IMM) || (opcode == OP);
   // Shift encodings are not implemented and act as a NOP
   assign arith_ok = arith && (funct3 != F3_SLL_NE) && (funct3 != F3_SR);
   assign slt_op   = arith && ((funct3 == F3_SLT) || (funct3 == F3_SLTU));

   // Only BEQ and BNE, other branch codes are skipped
   assign o_branch_op = (opcode == BRANCH) && (word[14:13] == 2'b00);
   assign o_branch_ne = (funct3 == F3_SLL_NE);
   assign o_jal_op    = (opcode == JAL);

   // Compares run as subtractions
   assign o_alu_sub = slt_op || o_branch_op ||
                      ((opcode == OP) && (funct3 == F3_ADD_EQ) && word[30]);
   assign o_alu_bool_op = word[13:12];
   assign o_alu_cmp_eq  = o_branch_op;
   assign o_alu_cmp_sig = !word[12];
   assign o_op_b_imm    = (opcode == OP_IMM);

   always_comb begin
      case (funct3)
         F3_ADD_EQ:       o_alu_rd_sel = 2'b00;
         F3_SLT, F3_SLTU: o_alu_rd_sel = 2'b10;
         default:         o_alu_rd_sel = 2'b01;
      endcase
   end

   // 00 ALU, 01 link, 10 upper immediate
   assign o_rd_sel = o_jal_op ? 2'b01 : (opcode == LUI) ? 2'b10 : 2'b00;

   assign o_writes_rd    = arith_ok || (opcode == LUI) || o_jal_op;
   assign o_two_stage_op = o_branch_op || slt_op;

   // Immediate format 00 I, 01 U, 10 B, 11 J
   assign o_imm_fmt = o_jal_op ? 2'b11 :
                      (opcode == BRANCH) ? 2'b10 :
                      (opcode == LUI) ? 2'b01 : 2'b00;

endmodule

// ==== hdl/imm_decode.sv ====
`timescale 1ns/1ps

module imm_decode import isa_pkg::*; #(
   parameter int W = 4
) (
   input  logic         clk,
   input  logic         i_ibus_ack,
   input  instr_t       i_ibus_rdt,
   input  logic [1:0]   i_imm_fmt,
   input  logic         i_cnt_en,
   output reg_idx_t     o_rs1_idx,
   output reg_idx_t     o_rs2_idx,
   output reg_idx_t     o_rd_idx,
   output logic [W-1:0] o_imm
);

   logic [31:7] fld;
   logic        load;
   logic [31:0] imm_full;
   logic [31:0] imm_r;

   always_comb begin
      case (i_imm_fmt)
         2'b01:   imm_full = {fld[31:12], 12'h000};
         2'b10:   imm_full = {{20{fld[31]}}, fld[7], fld[30:25], fld[11:8], 1'b0};
         2'b11:   imm_full = {{12{fld[31]}}, fld[19:12], fld[20], fld[30:21], 1'b0};
         default: imm_full = {{21{fld[31]}}, fld[30:20]};
      endcase
   end

   // Format is only known once decode holds the word, so load a cycle later
   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         fld <= i_ibus_rdt[31:7];
      end
      load <= i_ibus_ack;
      if (load) begin
         imm_r <= imm_full;
      end else if (i_cnt_en) begin
         // Rotate so a second pass sees the same immediate
         imm_r <= {imm_r[W-1:0], imm_r[31:W]};
      end
   end

   assign o_imm     = imm_r[W-1:0];
   assign o_rs1_idx = fld[19:15];
   assign o_rs2_idx = fld[24:20];
   assign o_rd_idx  = fld[11:7];

endmodule

// ==== hdl/serial_alu.sv ====
`timescale 1ns/1ps

module serial_alu #(
   parameter int W = 4
) (
   input  logic         clk,
   input  logic         i_cnt_en,
   input  logic         i_cnt0,
   input  logic         i_cnt_last,
   input  logic         i_sub,
   input  logic [1:0]   i_bool_op,
   input  logic         i_cmp_eq,
   input  logic         i_cmp_sig,
   input  logic [1:0]   i_rd_sel,
   input  logic         i_op_b_imm,
   input  logic [W-1:0] i_rs1,
   input  logic [W-1:0] i_rs2,
   input  logic [W-1:0] i_imm,
   output logic [W-1:0] o_rd,
   output logic         o_cmp_result
);

   logic [W-1:0] op_b;
   logic [W-1:0] b_in;
   logic [W-1:0] sum;
   logic [W-1:0] bool_res;
   logic [W-1:0] slt_res;
   logic         carry_in;
   logic         carry_out;
   logic         carry_r;
   logic         eq_r;
   logic         eq_now;
   logic         lt_now;
   logic         cmp_r;

   assign op_b     = i_op_b_imm ? i_imm : i_rs2;
   assign b_in     = i_sub ? ~op_b : op_b;
   assign carry_in = i_cnt0 ? i_sub : carry_r;
   assign {carry_out, sum} = {1'b0, i_rs1} + {1'b0, b_in} + {{W{1'b0}}, carry_in};

   assign bool_res = !i_bool_op[1] ? (i_rs1 ^ op_b) :
                     i_bool_op[0] ? (i_rs1 & op_b) : (i_rs1 | op_b);

   assign eq_now = (i_cnt0 || eq_r) && (i_rs1 == op_b);

   // Valid in the top slice; on differing signs the sum sign is not used
   assign lt_now = (i_rs1[W-1] ^ op_b[W-1]) ?
                   (i_cmp_sig ? i_rs1[W-1] : op_b[W-1]) : sum[W-1];

   assign o_cmp_result = i_cmp_eq ? eq_now : lt_now;

   // SLT result comes from the previous pass
   assign slt_res = W'(cmp_r && i_cnt0);

   always_comb begin
      case (i_rd_sel)
         2'b00:   o_rd = sum;
         2'b01:   o_rd = bool_res;
         default: o_rd = slt_res;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_r <= carry_out;
         eq_r    <= eq_now;
         if (i_cnt_last) begin
            cmp_r <= o_cmp_result;
         end
      end
   end

endmodule

// ==== hdl/pc_ctrl.sv ====
`timescale 1ns/1ps

module pc_ctrl import core_pkg::*; #(
   parameter int  W        = 4,
   parameter pc_t RESET_PC = 32'h0000_0000
) (
   input  logic         clk,
   input  logic         i_rst_n,
   input  logic         i_pc_en,
   input  logic         i_cnt_en,
   input  logic         i_cnt0,
   input  logic         i_jal_op,
   input  logic         i_take_branch,
   input  logic [W-1:0] i_imm,
   output pc_t          o_ibus_adr,
   output logic [W-1:0] o_link
);

   // Slice that holds bit 2, and the position of that bit within it
   localparam int          FOUR_SLICE = 2 / W;
   localparam logic [31:0] FOUR_WORD  = 32'(1) << (2 % W);
   localparam logic [W-1:0] FOUR_BIT  = FOUR_WORD[W-1:0];

   pc_t          pc_r;
   logic [1:0]   pos_q;
   logic [2:0]   pos;
   logic [W-1:0] four;
   logic [W-1:0] pc4;
   logic [W-1:0] pci;
   logic         c4_r;
   logic         ci_r;
   logic         c4_out;
   logic         ci_out;

   // Delayed copies of cnt0 mark the slice holding bit 2
   assign pos  = {pos_q, i_cnt0};
   assign four = pos[FOUR_SLICE] ? FOUR_BIT : '0;

   assign {c4_out, pc4} = {1'b0, pc_r[W-1:0]} + {1'b0, four} +
                          {{W{1'b0}}, !i_cnt0 && c4_r};
   assign {ci_out, pci} = {1'b0, pc_r[W-1:0]} + {1'b0, i_imm} +
                          {{W{1'b0}}, !i_cnt0 && ci_r};

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         pc_r  <= RESET_PC;
         pos_q <= '0;
         c4_r  <= 1'b0;
         ci_r  <= 1'b0;
      end else if (i_cnt_en) begin
         pos_q <= pos[1:0];
         c4_r  <= c4_out;
         ci_r  <= ci_out;
         if (i_pc_en) begin
            pc_r <= {((i_jal_op || i_take_branch) ? pci : pc4), pc_r[31:W]};
         end
      end
   end

   assign o_ibus_adr = pc_r;
   assign o_link     = pc4;

   // Outside a PC pass the register holds a whole word-aligned address
   a_pc_aligned: assert property (@(posedge clk) disable iff (!i_rst_n)
      !i_pc_en |-> (pc_r[1:0] == 2'b00));

endmodule

// ==== hdl/rf_if.sv ====
`timescale 1ns/1ps

module rf_if import isa_pkg::*; #(
   parameter int W = 4
) (
   input  logic         clk,
   input  logic         i_rst_n,
   input  logic         i_cnt_en,
   input  logic         i_init,
   input  logic [1:0]   i_rd_sel,
   input  logic         i_writes_rd,
   input  reg_idx_t     i_rd_idx,
   input  reg_idx_t     i_rs1_idx,
   input  reg_idx_t     i_rs2_idx,
   input  logic [W-1:0] i_alu_rd,
   input  logic [W-1:0] i_link,
   input  logic [W-1:0] i_imm,
   output logic         o_wen0,
   output reg_idx_t     o_wreg0,
   output logic [W-1:0] o_wdata0,
   output reg_idx_t     o_rreg0,
   output reg_idx_t     o_rreg1
);

   // Compare pass of a two-stage op never writes
   assign o_wen0  = i_cnt_en && !i_init && i_writes_rd && (i_rd_idx != '0);
   assign o_wreg0 = i_rd_idx;
   assign o_rreg0 = i_rs1_idx;
   assign o_rreg1 = i_rs2_idx;

   assign o_wdata0 = (i_rd_sel == 2'b01) ? i_link :
                     (i_rd_sel == 2'b10) ? i_imm : i_alu_rd;

   // Register indices hold for the whole pass
   a_idx_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_cnt_en |=> (!i_cnt_en ||
                    ($stable(o_wreg0) && $stable(o_rreg0) && $stable(o_rreg1))));

endmodule

// ==== hdl/serial_core_top.sv ====
`timescale 1ns/1ps

module serial_core_top import isa_pkg::*, core_pkg::*; #(
   parameter int  W        = 4,
   parameter pc_t RESET_PC = 32'h0000_0000
) (
   input  logic         clk,
   input  logic         i_rst_n,
   output logic         o_ibus_cyc,
   output pc_t          o_ibus_adr,
   input  logic         i_ibus_ack,
   input  instr_t       i_ibus_rdt,
   output logic         o_rf_rreq,
   input  logic         i_rf_ready,
   output reg_idx_t     o_rreg0,
   output reg_idx_t     o_rreg1,
   input  logic [W-1:0] i_rdata0,
   input  logic [W-1:0] i_rdata1,
   output logic         o_wen0,
   output reg_idx_t     o_wreg0,
   output logic [W-1:0] o_wdata0
);

   logic         cnt_en, cnt0, cnt_last, init, pc_en, take_branch, cmp_result;
   logic         alu_sub, alu_cmp_eq, alu_cmp_sig, op_b_imm;
   logic [1:0]   alu_bool_op, alu_rd_sel, rd_sel, imm_fmt;
   logic         writes_rd, two_stage_op, branch_op, branch_ne, jal_op;
   reg_idx_t     rs1_idx, rs2_idx, rd_idx;
   logic [W-1:0] imm, alu_rd, link;

   serial_state #(.W(W)) u_state (
      .clk(clk), .i_rst_n(i_rst_n),
      .i_ibus_ack(i_ibus_ack), .i_rf_ready(i_rf_ready),
      .i_two_stage_op(two_stage_op), .i_branch_op(branch_op),
      .i_branch_ne(branch_ne), .i_cmp_result(cmp_result),
      .o_ibus_cyc(o_ibus_cyc), .o_rf_rreq(o_rf_rreq),
      .o_cnt_en(cnt_en), .o_cnt0(cnt0), .o_cnt_last(cnt_last),
      .o_init(init), .o_pc_en(pc_en), .o_take_branch(take_branch));

   instr_decode u_decode (
      .clk(clk), .i_ibus_ack(i_ibus_ack), .i_ibus_rdt(i_ibus_rdt),
      .o_alu_sub(alu_sub), .o_alu_bool_op(alu_bool_op),
      .o_alu_cmp_eq(alu_cmp_eq), .o_alu_cmp_sig(alu_cmp_sig),
      .o_alu_rd_sel(alu_rd_sel), .o_op_b_imm(op_b_imm), .o_rd_sel(rd_sel),
      .o_writes_rd(writes_rd), .o_two_stage_op(two_stage_op),
      .o_branch_op(branch_op), .o_branch_ne(branch_ne),
      .o_jal_op(jal_op), .o_imm_fmt(imm_fmt));

   imm_decode #(.W(W)) u_immdec (
      .clk(clk), .i_ibus_ack(i_ibus_ack), .i_ibus_rdt(i_ibus_rdt),
      .i_imm_fmt(imm_fmt), .i_cnt_en(cnt_en),
      .o_rs1_idx(rs1_idx), .o_rs2_idx(rs2_idx), .o_rd_idx(rd_idx), .o_imm(imm));

   serial_alu #(.W(W)) u_alu (
      .clk(clk), .i_cnt_en(cnt_en), .i_cnt0(cnt0), .i_cnt_last(cnt_last),
      .i_sub(alu_sub), .i_bool_op(alu_bool_op), .i_cmp_eq(alu_cmp_eq),
      .i_cmp_sig(alu_cmp_sig), .i_rd_sel(alu_rd_sel), .i_op_b_imm(op_b_imm),
      .i_rs1(i_rdata0), .i_rs2(i_rdata1), .i_imm(imm),
      .o_rd(alu_rd), .o_cmp_result(cmp_result));

   pc_ctrl #(.W(W), .RESET_PC(RESET_PC)) u_pc (
      .clk(clk), .i_rst_n(i_rst_n), .i_pc_en(pc_en), .i_cnt_en(cnt_en),
      .i_cnt0(cnt0), .i_jal_op(jal_op), .i_take_branch(take_branch),
      .i_imm(imm), .o_ibus_adr(o_ibus_adr), .o_link(link));

   rf_if #(.W(W)) u_rf_if (
      .clk(clk), .i_rst_n(i_rst_n), .i_cnt_en(cnt_en), .i_init(init),
      .i_rd_sel(rd_sel), .i_writes_rd(writes_rd), .i_rd_idx(rd_idx),
      .i_rs1_idx(rs1_idx), .i_rs2_idx(rs2_idx),
      .i_alu_rd(alu_rd), .i_link(link), .i_imm(imm),
      .o_wen0(o_wen0), .o_wreg0(o_wreg0), .o_wdata0(o_wdata0),
      .o_rreg0(o_rreg0), .o_rreg1(o_rreg1));

endmodule

// ==== test/tb_serial_core.sv ====
`timescale 1ns/1ps

module tb_serial_core import isa_pkg::*, core_pkg::*; ();

   localparam int          W        = 4;
   localparam pc_t         RESET_PC = 32'h0000_0000;
   localparam int          SLICES   = 32 / W;
   localparam int          TIMEOUT  = 40;
   localparam logic [15:0] SEED     = 16'd13316;

   logic         clk;
   logic         rst_n;
   logic         ibus_cyc;
   pc_t          ibus_adr;
   logic         ibus_ack;
   instr_t       ibus_rdt;
   logic         rf_rreq;
   logic         rf_ready;
   reg_idx_t     rreg0;
   reg_idx_t     rreg1;
   logic [W-1:0] rdata0;
   logic [W-1:0] rdata1;
   logic         wen0;
   reg_idx_t     wreg0;
   logic [W-1:0] wdata0;

   // Program words from 0x00, fetch list from 0x20, final x1 to x15 from 0x40
   logic [31:0]  golden [0:127];
   data_t        regs [0:31];
   logic [15:0]  lfsr;
   logic [6:0]   cur_opcode;

   serial_core_top #(.W(W), .RESET_PC(RESET_PC)) UUT (
      .clk(clk), .i_rst_n(rst_n),
      .o_ibus_cyc(ibus_cyc), .o_ibus_adr(ibus_adr),
      .i_ibus_ack(ibus_ack), .i_ibus_rdt(ibus_rdt),
      .o_rf_rreq(rf_rreq), .i_rf_ready(rf_ready),
      .o_rreg0(rreg0), .o_rreg1(rreg1),
      .i_rdata0(rdata0), .i_rdata1(rdata1),
      .o_wen0(wen0), .o_wreg0(wreg0), .o_wdata0(wdata0));

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [15:0] advance_lfsr(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // Two LFSR bits give a delay of 0 to 3 cycles
   task automatic draw_delay(output int d);
      d = 0;
      for (int i = 0; i < 2; i++) begin
         lfsr = advance_lfsr(lfsr);
         d = (d << 1) | int'(lfsr[0]);
      end
   endtask

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("=== FAIL ===");
      $fatal(1, "testbench stopped at the first error");
   endtask

   task automatic check_reg(input string name, input data_t expected, input data_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
      end
   endtask

   task automatic check_pc(input string name, input pc_t expected, input pc_t actual);
      if (actual !== expected) begin
         abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
      end
   endtask

   task automatic poll_fetch();
      int n;
      n = 0;
      while (!ibus_cyc) begin
         if (rf_rreq) begin
            abort_run("Register read request seen outside the read phase");
         end
         @(posedge clk);
         n++;
         if (n > TIMEOUT) begin
            abort_run("Timeout while waiting for an instruction fetch");
         end
      end
   endtask

   task automatic wait_read_request();
      int n;
      n = 0;
      while (!rf_rreq) begin
         @(posedge clk);
         n++;
         if (n > TIMEOUT) begin
            abort_run("Timeout while waiting for a register read request");
         end
      end
   endtask

   task automatic answer_fetch();
      pc_t    adr;
      instr_t word;
      int     d;
      adr = ibus_adr;
      if (adr[31:7] != '0) begin
         abort_run("Fetch address lies outside the program memory");
      end
      word = golden[{2'b00, adr[6:2]}];
      draw_delay(d);
      for (int i = 0; i < d; i++) begin
         @(posedge clk);
         if (!ibus_cyc || (ibus_adr !== adr)) begin
            abort_run("Fetch dropped or address changed before the ack");
         end
      end
      ibus_ack   <= 1'b1;
      ibus_rdt   <= word;
      cur_opcode <= word[6:0];
      @(posedge clk);
      ibus_ack <= 1'b0;
   endtask

   // Source values are taken when the request is seen and sent LSB slice first
   task automatic stream_operands();
      data_t a;
      data_t b;
      int    d;
      a = regs[rreg0];
      b = regs[rreg1];
      draw_delay(d);
      repeat (d) @(posedge clk);
      rf_ready <= 1'b1;
      @(posedge clk);
      rf_ready <= 1'b0;
      for (int k = 0; k < SLICES; k++) begin
         rdata0 <= W'(a >> (k * W));
         rdata1 <= W'(b >> (k * W));
         @(posedge clk);
      end
      rdata0 <= '0;
      rdata1 <= '0;
   endtask

   // Register file model that collects one write slice per enabled cycle
   initial begin
      data_t wr_acc;
      int    wr_cnt;
      wr_acc = '0;
      wr_cnt = 0;
      for (int i = 0; i < 32; i++) begin
         regs[5'(i)] = '0;
      end
      forever begin
         @(posedge clk);
         if (rst_n && wen0) begin
            if (wreg0 == '0) begin
               abort_run("Write enable raised for register x0");
            end
            if (cur_opcode == BRANCH) begin
               abort_run("Register write during a branch pass");
            end
            wr_acc = {wdata0, wr_acc[31:W]};
            wr_cnt = wr_cnt + 1;
            if (wr_cnt == SLICES) begin
               regs[wreg0] = wr_acc;
               wr_cnt = 0;
            end
         end
      end
   end

   initial begin
      int nexp;
      rst_n      <= 1'b0;
      ibus_ack   <= 1'b0;
      ibus_rdt   <= '0;
      rf_ready   <= 1'b0;
      rdata0     <= '0;
      rdata1     <= '0;
      cur_opcode <= '0;
      lfsr = SEED;
      $readmemh("test/core_golden.txt", golden);
      nexp = int'(golden[7'h20]);
      if (nexp == 0) begin
         abort_run("Golden file holds no fetch addresses");
      end
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      if (!ibus_cyc || rf_rreq || wen0) begin
         abort_run("Core does not start with a lone fetch after reset");
      end
      check_pc("reset address", RESET_PC, ibus_adr);
      for (int f = 0; f < nexp; f++) begin
         poll_fetch();
         check_pc($sformatf("fetch %0d", f), golden[7'(33 + f)], ibus_adr);
         // The last listed fetch only marks the end of the program
         if (f < nexp - 1) begin
            answer_fetch();
            wait_read_request();
            stream_operands();
         end
      end
      for (int r = 1; r < 16; r++) begin
         check_reg($sformatf("x%0d", r), golden[7'(63 + r)], regs[5'(r)]);
      end
      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== test/core_golden.txt ====
// One 32-bit hex word per entry, several entries per line
// @00 program words, @20 fetch count then fetch addresses, @40 final x1 to x15
@00
12300093 FFB00113 0F00C193 4040E213  // ADDI x1, ADDI x2 = -5, XORI x3, ORI x4
7F017293 00112313 00513393 00208433  // ANDI x5, SLTI x6, SLTIU x7, ADD x8
402084B3 00112533 001135B3 ABCDE637  // SUB x9, SLT x10, SLTU x11, LUI x12
00708013 003046B3 00227733 00208463  // ADDI to x0, XOR x13 from x0, AND x14, BEQ not taken
00209463 7FF00713 00318463 7FF00693  // BNE taken, skipped, BEQ taken, skipped
00529463 000C007EF 00000093 00000113 // BNE not taken, JAL x15 +12, two skipped words
FA1FF06F                             // JAL x0 back to 0x00
@20
00000016
00000000 00000004 00000008 0000000C 00000010 00000014 00000018 0000001C
00000020 00000024 00000028 0000002C 00000030 00000034 00000038 0000003C
00000040 00000048 00000050 00000054 00000060 00000000
@40
00000123 FFFFFFFB 000001D3 00000527 000007F0
00000001 00000000 0000011E 00000128 00000001
00000000 ABCDE000 000001D3 00000523 00000058

// ==== files.f ====
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/serial_state.sv
hdl/instr_decode.sv
hdl/imm_decode.sv
hdl/serial_alu.sv
hdl/pc_ctrl.sv
hdl/rf_if.sv
hdl/serial_core_top.sv
test/tb_serial_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" \
   && verilator --binary --timing --assert -j 0 --top-module tb_serial_core \
      -f files.f -o tb_serial_core \
   && ./obj_dir/tb_serial_core \
   || { echo "Simulation did not complete cleanly"; exit 1; }
